// File: fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Data and address width of the core
`define XLEN 32

// Fetch slots, outstanding requests and stored words counted together
`define FIFO_DEPTH 2

// Debug module entry points
`define DM_HALT_ADDR 32'h1a110800
`define DM_EXC_ADDR 32'h1a110808

// Low byte of the boot address below the upper bits of boot_addr_i
`define BOOT_OFFSET 8'h80

`endif

// File: fetch_ctrl_pkg.sv
`include "fetch_params.svh"

package fetch_ctrl_pkg;

	typedef enum logic [2:0] {
		PC_BOOT,
		PC_JUMP,
		PC_EXC,
		PC_ERET,
		PC_DRET
	} pc_sel_e;

	typedef enum logic [1:0] {
		EXC_PC_EXC,
		EXC_PC_IRQ,
		EXC_PC_DBD,
		EXC_PC_DBG_EXC
	} exc_sel_e;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		FULL
	} fetch_state_e;

	typedef struct packed {
		logic pc_set;
		pc_sel_e pc_sel;
		exc_sel_e exc_sel;
		logic [5:0] cause; // Bit 5 flags an interrupt
	} redirect_t;

	typedef struct packed {
		logic [`XLEN-1:0] instr;
		logic [`XLEN-1:0] addr;
		logic err;
	} fetch_entry_t;

endpackage

// File: instr_bus_pkg.sv
`include "fetch_params.svh"

package instr_bus_pkg;

	// Request held stable until granted
	typedef struct packed {
		logic req;
		logic [`XLEN-1:0] addr;
	} ibus_req_t;

	// One in-order rvalid per grant
	typedef struct packed {
		logic gnt;
		logic rvalid;
		logic [`XLEN-1:0] rdata;
		logic err; // rdata is meaningless when set
	} ibus_rsp_t;

endpackage

// File: pc_target_mux.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module pc_target_mux (
	input fetch_ctrl_pkg::redirect_t redirect_i,
	input logic [`XLEN-1:0] boot_addr_i,
	input logic [`XLEN-1:0] csr_mtvec_i,
	input logic [`XLEN-1:0] csr_mepc_i,
	input logic [`XLEN-1:0] csr_depc_i,
	input logic [`XLEN-1:0] branch_target_i,
	output logic [`XLEN-1:0] target_o
);
	import fetch_ctrl_pkg::*;

	logic [`XLEN-1:0] boot_target;
	logic [`XLEN-1:0] exc_target;

	assign boot_target = {boot_addr_i[`XLEN-1:8], `BOOT_OFFSET};

	// In vectored mode interrupts land at base plus four times the cause
	always_comb begin
		case (redirect_i.exc_sel)
			EXC_PC_EXC: exc_target = {csr_mtvec_i[`XLEN-1:8], 8'h00};
			EXC_PC_IRQ: exc_target = {csr_mtvec_i[`XLEN-1:8], 1'b0, redirect_i.cause[4:0], 2'b00};
			EXC_PC_DBD: exc_target = `DM_HALT_ADDR;
			EXC_PC_DBG_EXC: exc_target = `DM_EXC_ADDR;
			default: exc_target = {csr_mtvec_i[`XLEN-1:8], 8'h00};
		endcase
	end

	always_comb begin
		case (redirect_i.pc_sel)
			PC_BOOT: target_o = boot_target;
			PC_JUMP: target_o = branch_target_i;
			PC_EXC: target_o = exc_target;
			PC_ERET: target_o = csr_mepc_i;
			PC_DRET: target_o = csr_depc_i;
			default: target_o = boot_target;
		endcase
	end

endmodule

// File: fetch_fsm.sv
`timescale 1ns/10ps

module fetch_fsm (
	input logic clk_i,
	input logic rst_ni,
	input logic req_i,
	input fetch_ctrl_pkg::redirect_t redirect_i,
	input logic space_i,
	input logic gnt_i,
	output logic mem_req_o,
	output fetch_ctrl_pkg::fetch_state_e state_o
);
	import fetch_ctrl_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;
	logic req_pending;

	assign mem_req_o = (state_q == ISSUE) & space_i;
	assign req_pending = mem_req_o & ~gnt_i; // Bus request must stay up until granted

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (req_i) begin
					state_d = ISSUE;
				end
			end
			ISSUE: begin
				if (!req_i && !req_pending) begin
					state_d = IDLE;
				end else if (!space_i) begin
					state_d = FULL;
				end
			end
			FULL: begin
				if (!req_i) begin
					state_d = IDLE;
				end else if (space_i) begin
					state_d = ISSUE;
				end
			end
			default: state_d = IDLE;
		endcase
		// Redirect restarts without waiting on stale responses
		if (redirect_i.pc_set) begin
			state_d = ISSUE;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign state_o = state_q;

endmodule

// File: fetch_addr_counter.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_addr_counter (
	input logic clk_i,
	input logic rst_ni,
	input logic load_i,
	input logic [`XLEN-1:0] load_addr_i,
	input logic grant_i,
	output logic [`XLEN-1:0] addr_o
);

	localparam logic [`XLEN-1:0] INSTR_STEP = 4; // Only aligned 32-bit instructions

	logic boot_q;
	logic [`XLEN-1:0] addr_q;

	// The first cycle out of reset takes the boot target from the mux
	// before the FSM can issue its first request
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			boot_q <= 1'b1;
			addr_q <= '0;
		end else begin
			boot_q <= 1'b0;
			if (load_i || boot_q) begin
				addr_q <= load_addr_i; // Redirect wins over a grant in the same cycle
			end else if (grant_i) begin
				addr_q <= addr_q + INSTR_STEP;
			end
		end
	end

	assign addr_o = addr_q;

endmodule

// File: fetch_fifo.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_fifo (
	input logic clk_i,
	input logic rst_ni,
	input logic flush_i,
	input logic grant_i,
	input logic [`XLEN-1:0] addr_i,
	input instr_bus_pkg::ibus_rsp_t rsp_i,
	input logic pop_i,
	output logic space_o,
	output logic valid_o,
	output fetch_ctrl_pkg::fetch_entry_t entry_o
);
	import fetch_ctrl_pkg::*;

	localparam int DEPTH = `FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_entry_t slots_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q; // Next slot to allocate on a grant
	logic [PTR_W-1:0] fill_ptr_q; // Oldest live request awaiting data
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] live_cnt_q;
	logic [CNT_W-1:0] stale_cnt_q;
	logic [CNT_W-1:0] stored_cnt_q;
	logic rsp_stale;
	logic rsp_live;

	function automatic logic [PTR_W-1:0] ptr_incr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Responses come in order, so stale ones always arrive first
	assign rsp_stale = rsp_i.rvalid & (stale_cnt_q != '0);
	assign rsp_live = rsp_i.rvalid & ~rsp_stale & ~flush_i;

	assign space_o = (live_cnt_q + stale_cnt_q + stored_cnt_q) < CNT_W'(DEPTH);
	assign valid_o = (stored_cnt_q != '0);
	assign entry_o = slots_q[rd_ptr_q];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			fill_ptr_q <= '0;
			rd_ptr_q <= '0;
			live_cnt_q <= '0;
			stale_cnt_q <= '0;
			stored_cnt_q <= '0;
		end else if (flush_i) begin
			wr_ptr_q <= '0;
			fill_ptr_q <= '0;
			rd_ptr_q <= '0;
			live_cnt_q <= '0;
			stored_cnt_q <= '0;
			// A grant in the flush cycle is already stale
			stale_cnt_q <= stale_cnt_q + live_cnt_q + CNT_W'(grant_i) - CNT_W'(rsp_i.rvalid);
		end else begin
			if (grant_i) begin
				wr_ptr_q <= ptr_incr(wr_ptr_q);
			end
			if (rsp_live) begin
				fill_ptr_q <= ptr_incr(fill_ptr_q);
			end
			if (pop_i) begin
				rd_ptr_q <= ptr_incr(rd_ptr_q);
			end
			live_cnt_q <= live_cnt_q + CNT_W'(grant_i) - CNT_W'(rsp_live);
			stale_cnt_q <= stale_cnt_q - CNT_W'(rsp_stale);
			stored_cnt_q <= stored_cnt_q + CNT_W'(rsp_live) - CNT_W'(pop_i);
		end
	end

	always_ff @(posedge clk_i) begin
		if (grant_i && !flush_i) begin
			slots_q[wr_ptr_q].addr <= addr_i;
		end
		if (rsp_live) begin
			slots_q[fill_ptr_q].instr <= rsp_i.rdata;
			slots_q[fill_ptr_q].err <= rsp_i.err;
		end
	end

endmodule

// File: if_id_reg.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module if_id_reg (
	input logic clk_i,
	input logic rst_ni,
	input fetch_ctrl_pkg::fetch_entry_t entry_i,
	input logic entry_valid_i,
	input logic id_in_ready_i,
	input logic pc_set_i,
	input logic instr_valid_clear_i,
	output logic instr_valid_id_o,
	output logic instr_new_id_o,
	output logic [`XLEN-1:0] instr_rdata_id_o,
	output logic [`XLEN-1:0] pc_id_o,
	output logic instr_fetch_err_o,
	output logic pc_mismatch_alert_o
);

	logic capture;
	logic prev_seq_q; // Last captured instruction came in sequence
	logic [`XLEN-1:0] pc_next_seq;

	assign capture = entry_valid_i & id_in_ready_i & ~pc_set_i; // No accept during a redirect

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			instr_valid_id_o <= 1'b0;
			instr_new_id_o <= 1'b0;
			prev_seq_q <= 1'b0;
		end else begin
			instr_valid_id_o <= capture | (instr_valid_id_o & ~instr_valid_clear_i);
			instr_new_id_o <= capture;
			prev_seq_q <= (prev_seq_q | capture) & ~pc_set_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (capture) begin
			instr_rdata_id_o <= entry_i.instr;
			pc_id_o <= entry_i.addr;
			instr_fetch_err_o <= entry_i.err;
		end
	end

	assign pc_next_seq = pc_id_o + `XLEN'(4);
	assign pc_mismatch_alert_o = prev_seq_q & entry_valid_i & (entry_i.addr != pc_next_seq);

endmodule

// File: if_stage.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module if_stage (
	input logic clk_i,
	input logic rst_ni,
	input logic req_i,
	input logic [`XLEN-1:0] boot_addr_i,
	input fetch_ctrl_pkg::redirect_t redirect_i,
	input logic [`XLEN-1:0] csr_mtvec_i,
	input logic [`XLEN-1:0] csr_mepc_i,
	input logic [`XLEN-1:0] csr_depc_i,
	input logic [`XLEN-1:0] branch_target_i,
	output instr_bus_pkg::ibus_req_t ibus_req_o,
	input instr_bus_pkg::ibus_rsp_t ibus_rsp_i,
	input logic id_in_ready_i,
	input logic instr_valid_clear_i,
	output logic instr_valid_id_o,
	output logic instr_new_id_o,
	output logic [`XLEN-1:0] instr_rdata_id_o,
	output logic [`XLEN-1:0] pc_id_o,
	output logic instr_fetch_err_o,
	output logic pc_mismatch_alert_o,
	output logic csr_mtvec_init_o,
	output logic if_busy_o
);
	import fetch_ctrl_pkg::*;

	logic [`XLEN-1:0] target;
	logic [`XLEN-1:0] fetch_addr;
	logic mem_req;
	logic grant;
	logic space;
	logic fifo_valid;
	logic fifo_pop;
	fetch_entry_t fifo_entry;
	fetch_state_e fsm_state;

	assign grant = mem_req & ibus_rsp_i.gnt;
	assign fifo_pop = fifo_valid & id_in_ready_i;
	assign ibus_req_o.req = mem_req;
	assign ibus_req_o.addr = fetch_addr;

	assign csr_mtvec_init_o = redirect_i.pc_set & (redirect_i.pc_sel == PC_BOOT);
	assign if_busy_o = (fsm_state != IDLE);

	pc_target_mux u_pc_target_mux (
		.redirect_i(redirect_i),
		.boot_addr_i(boot_addr_i),
		.csr_mtvec_i(csr_mtvec_i),
		.csr_mepc_i(csr_mepc_i),
		.csr_depc_i(csr_depc_i),
		.branch_target_i(branch_target_i),
		.target_o(target)
	);

	fetch_fsm u_fetch_fsm (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.req_i(req_i),
		.redirect_i(redirect_i),
		.space_i(space),
		.gnt_i(ibus_rsp_i.gnt),
		.mem_req_o(mem_req),
		.state_o(fsm_state)
	);

	fetch_addr_counter u_fetch_addr_counter (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.load_i(redirect_i.pc_set),
		.load_addr_i(target),
		.grant_i(grant),
		.addr_o(fetch_addr)
	);

	fetch_fifo u_fetch_fifo (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.flush_i(redirect_i.pc_set),
		.grant_i(grant),
		.addr_i(fetch_addr),
		.rsp_i(ibus_rsp_i),
		.pop_i(fifo_pop),
		.space_o(space),
		.valid_o(fifo_valid),
		.entry_o(fifo_entry)
	);

	if_id_reg u_if_id_reg (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.entry_i(fifo_entry),
		.entry_valid_i(fifo_valid),
		.id_in_ready_i(id_in_ready_i),
		.pc_set_i(redirect_i.pc_set),
		.instr_valid_clear_i(instr_valid_clear_i),
		.instr_valid_id_o(instr_valid_id_o),
		.instr_new_id_o(instr_new_id_o),
		.instr_rdata_id_o(instr_rdata_id_o),
		.pc_id_o(pc_id_o),
		.instr_fetch_err_o(instr_fetch_err_o),
		.pc_mismatch_alert_o(pc_mismatch_alert_o)
	);

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int HALF_NS = 2,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_no
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

	initial begin
		rst_no = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_no = 1'b1; // Released away from the sampling edge
	end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model #(
	parameter logic [31:0] SEED = 32'h90c7863f
) (
	input logic clk_i,
	input logic rst_ni,
	input instr_bus_pkg::ibus_req_t ibus_req_i,
	output instr_bus_pkg::ibus_rsp_t ibus_rsp_o
);

	localparam logic [31:0] DATA_KEY = 32'h5a5a5a5a;

	integer seed;
	logic [31:0] addr_q [$]; // Granted addresses in grant order
	int unsigned due_q [$]; // Earliest cycle for each response
	int unsigned cyc;
	int unsigned gnt_wait;
	logic [31:0] rsp_addr;

	function automatic int unsigned rand_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	// Outputs change on the falling edge and the DUT samples on the rising one
	initial begin
		seed = SEED;
		cyc = 0;
		gnt_wait = 0;
		ibus_rsp_o = '0;
		forever begin
			@(negedge clk_i);
			cyc = cyc + 1;
			ibus_rsp_o = '0;
			if (!rst_ni) begin
				addr_q.delete();
				due_q.delete();
				gnt_wait = 0;
			end else begin
				if (addr_q.size() != 0 && due_q[0] <= cyc) begin
					rsp_addr = addr_q[0];
					addr_q.delete(0);
					due_q.delete(0);
					ibus_rsp_o.rvalid = 1'b1;
					ibus_rsp_o.err = (rsp_addr[6:2] == 5'h13); // Injected bus error
					ibus_rsp_o.rdata = ibus_rsp_o.err ? ~(rsp_addr ^ DATA_KEY)
						: rsp_addr ^ DATA_KEY;
				end
				// Request and address come from DUT registers and hold until the next edge
				if (ibus_req_i.req) begin
					if (gnt_wait == 0) begin
						ibus_rsp_o.gnt = 1'b1;
						addr_q.push_back(ibus_req_i.addr);
						due_q.push_back(cyc + 1 + rand_delay());
						gnt_wait = rand_delay();
					end else begin
						gnt_wait = gnt_wait - 1;
					end
				end
			end
		end
	end

endmodule

// File: tb_if_stage.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module tb_if_stage;
	import fetch_ctrl_pkg::*;
	import instr_bus_pkg::*;

	localparam logic [31:0] SEED = 32'h90c7863f;
	localparam logic [31:0] DATA_KEY = 32'h5a5a5a5a; // Memory returns address XOR key
	localparam int RESET_LIMIT = 20;

	logic clk;
	logic rst_n;
	logic req;
	logic [`XLEN-1:0] boot_addr;
	redirect_t redirect;
	logic [`XLEN-1:0] csr_mtvec;
	logic [`XLEN-1:0] csr_mepc;
	logic [`XLEN-1:0] csr_depc;
	logic [`XLEN-1:0] branch_target;
	ibus_req_t ibus_req;
	ibus_rsp_t ibus_rsp;
	logic id_in_ready;
	logic instr_valid_clear;
	logic instr_valid_id;
	logic instr_new_id;
	logic [`XLEN-1:0] instr_rdata_id;
	logic [`XLEN-1:0] pc_id;
	logic instr_fetch_err;
	logic pc_mismatch_alert;
	logic csr_mtvec_init;
	logic if_busy;

	integer seed;
	redirect_t pending; // Applied at the next drive
	logic [`XLEN-1:0] exp_addr;
	int unsigned delivered;
	int unsigned err_seen;
	int unsigned ready_odds; // Out of four
	logic valid_model;
	logic prev_ready;
	logic prev_clear;
	logic prev_pc_set;
	logic prev_boot;

	tb_clk_gen u_clk_gen (
		.clk_o(clk),
		.rst_no(rst_n)
	);

	tb_mem_model #(
		.SEED(SEED)
	) u_mem_model (
		.clk_i(clk),
		.rst_ni(rst_n),
		.ibus_req_i(ibus_req),
		.ibus_rsp_o(ibus_rsp)
	);

	if_stage u_if_stage (
		.clk_i(clk),
		.rst_ni(rst_n),
		.req_i(req),
		.boot_addr_i(boot_addr),
		.redirect_i(redirect),
		.csr_mtvec_i(csr_mtvec),
		.csr_mepc_i(csr_mepc),
		.csr_depc_i(csr_depc),
		.branch_target_i(branch_target),
		.ibus_req_o(ibus_req),
		.ibus_rsp_i(ibus_rsp),
		.id_in_ready_i(id_in_ready),
		.instr_valid_clear_i(instr_valid_clear),
		.instr_valid_id_o(instr_valid_id),
		.instr_new_id_o(instr_new_id),
		.instr_rdata_id_o(instr_rdata_id),
		.pc_id_o(pc_id),
		.instr_fetch_err_o(instr_fetch_err),
		.pc_mismatch_alert_o(pc_mismatch_alert),
		.csr_mtvec_init_o(csr_mtvec_init),
		.if_busy_o(if_busy)
	);

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] rand_addr();
		return $unsigned($random(seed)) & 32'hfffffffc;
	endfunction

	// Reference rules for the redirect target
	function automatic logic [31:0] target_of(input redirect_t r);
		case (r.pc_sel)
			PC_BOOT: return {boot_addr[31:8], 8'h80};
			PC_JUMP: return branch_target;
			PC_ERET: return csr_mepc;
			PC_DRET: return csr_depc;
			default: begin
				case (r.exc_sel)
					EXC_PC_EXC: return csr_mtvec & 32'hffffff00;
					EXC_PC_IRQ: return (csr_mtvec & 32'hffffff00) | (32'(r.cause[4:0]) << 2);
					EXC_PC_DBD: return `DM_HALT_ADDR;
					default: return `DM_EXC_ADDR;
				endcase
			end
		endcase
	endfunction

	task automatic fail_run(input string why);
		$display("FAIL: see errors above");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			fail_run("value mismatch");
		end
	endtask

	task automatic drive();
		id_in_ready = (rand_below(4) < ready_odds);
		instr_valid_clear = (rand_below(2) == 1);
		redirect = pending;
		if (pending.pc_set) begin
			exp_addr = target_of(pending); // Model restarts at the target
		end
		prev_ready = id_in_ready;
		prev_clear = instr_valid_clear;
		prev_pc_set = pending.pc_set;
		prev_boot = (pending.pc_sel == PC_BOOT);
		pending.pc_set = 1'b0;
	endtask

	task automatic observe();
		logic exp_valid;
		check("csr_mtvec_init_o", 32'(csr_mtvec_init), 32'(prev_pc_set && prev_boot));
		check("pc_mismatch_alert_o", 32'(pc_mismatch_alert), 32'(0));
		check("if_busy_o", 32'(if_busy), 32'(req)); // Fetch stays active while requested
		if (prev_pc_set) begin
			check("ibus_req_o.addr", ibus_req.addr, exp_addr); // Counter holds the new target
		end
		if (instr_new_id) begin
			check("id_in_ready_i at capture", 32'(prev_ready), 32'(1));
			check("pc_set at capture", 32'(prev_pc_set), 32'(0));
			check("pc_id_o", pc_id, exp_addr);
			check("instr_fetch_err_o", 32'(instr_fetch_err), 32'(exp_addr[6:2] == 5'h13));
			if (exp_addr[6:2] == 5'h13) begin
				err_seen++;
			end else begin
				check("instr_rdata_id_o", instr_rdata_id, exp_addr ^ DATA_KEY);
			end
			exp_addr = exp_addr + 4;
			delivered++;
		end
		exp_valid = instr_new_id | (valid_model & ~prev_clear);
		check("instr_valid_id_o", 32'(instr_valid_id), 32'(exp_valid));
		valid_model = exp_valid;
	endtask

	task automatic cycle();
		drive();
		@(negedge clk);
		observe();
	endtask

	task automatic deliver(input int unsigned n);
		int unsigned goal;
		int unsigned waited;
		goal = delivered + n;
		waited = 0;
		while (delivered < goal && waited < 40 * n + 60) begin
			cycle();
			waited++;
		end
		if (delivered < goal) begin
			fail_run("instructions did not reach decode in time");
		end
	endtask

	task automatic pick_return(input bit fresh);
		if (fresh) begin
			branch_target = rand_addr();
			csr_mepc = rand_addr();
			csr_depc = rand_addr();
		end
		pending = redirect;
		pending.pc_set = 1'b1;
		case (rand_below(3))
			0: pending.pc_sel = PC_JUMP;
			1: pending.pc_sel = PC_ERET;
			default: pending.pc_sel = PC_DRET;
		endcase
	endtask

	initial begin
		int unsigned waited;
		seed = SEED;
		req = 1'b0;
		boot_addr = rand_addr();
		redirect = '0;
		pending = '0;
		csr_mtvec = '0;
		csr_mepc = '0;
		csr_depc = '0;
		branch_target = '0;
		id_in_ready = 1'b0;
		instr_valid_clear = 1'b0;
		exp_addr = '0;
		delivered = 0;
		err_seen = 0;
		ready_odds = 3;
		valid_model = 1'b0;
		prev_ready = 1'b0;
		prev_clear = 1'b0;
		prev_pc_set = 1'b0;
		prev_boot = 1'b0;

		waited = 0;
		while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
			@(negedge clk);
			check("ibus_req_o.req", 32'(ibus_req.req), 32'(0));
			check("instr_valid_id_o", 32'(instr_valid_id), 32'(0));
			check("instr_new_id_o", 32'(instr_new_id), 32'(0));
			check("pc_mismatch_alert_o", 32'(pc_mismatch_alert), 32'(0));
			check("if_busy_o", 32'(if_busy), 32'(0));
			waited++;
		end
		if (rst_n !== 1'b1) begin
			fail_run("reset was never released");
		end

		// Boot fetch
		req = 1'b1;
		pending.pc_set = 1'b1;
		pending.pc_sel = PC_BOOT;
		deliver(40);

		// Decode mostly stalled
		ready_odds = 1;
		deliver(30);
		ready_odds = 3;

		// Jumps and returns with some back to back
		repeat (12) begin
			pick_return(1'b1);
			if (rand_below(3) == 0) begin
				cycle();
				pick_return(1'b0);
			end
			deliver(1 + rand_below(8));
		end

		// Exception vectors
		repeat (2) begin
			for (int s = 0; s < 4; s++) begin
				csr_mtvec = rand_addr();
				pending = '0;
				pending.pc_set = 1'b1;
				pending.pc_sel = PC_EXC;
				pending.exc_sel = exc_sel_e'(s[1:0]);
				pending.cause = 6'(rand_below(64));
				deliver(2 + rand_below(5));
			end
		end

		// Boot again from a new base
		boot_addr = rand_addr();
		pending = '0;
		pending.pc_set = 1'b1;
		pending.pc_sel = PC_BOOT;
		deliver(24);

		if (err_seen == 0) begin
			fail_run("no fetch error reached decode");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

// File: list.f
+incdir+.
fetch_ctrl_pkg.sv
instr_bus_pkg.sv
pc_target_mux.sv
fetch_fsm.sv
fetch_addr_counter.sv
fetch_fifo.sv
if_id_reg.sv
if_stage.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_if_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps -f list.f --top-module tb_if_stage \
	-o sim_if_stage && ./obj_dir/sim_if_stage || exit 1
